/* logic/cachePkg.sv */
package cachePkg;

  // address split into tag, index and offset
  localparam int ADDR_W   = 32;
  localparam int XLEN     = 64;
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // array geometry
  localparam int NUM_SETS = 1 << INDEX_W;
  localparam int HALF_W   = 128;
  localparam int LINE_W   = 2 * HALF_W;

  // memory side, one 64-bit word per beat
  localparam int BEATS    = LINE_W / XLEN;

  // request credits the cache may hold at once
  localparam int MEM_CREDITS = 2;
  localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

  // payload of the tag SRAMs
  typedef logic [TAG_W-1:0] tagEntry_t;

endpackage

/* logic/spRam.sv */
`timescale 1ns/1ps

// behavioural stand-in for the single-port SRAM macro
module spRam
  import cachePkg::*;
#(
  parameter type payload_t = logic [HALF_W-1:0]
) (
  input  logic               clk,
  input  logic               en_i,
  input  logic               we_i,
  input  logic [INDEX_W-1:0] addr_i,
  input  payload_t           wdata_i,
  output payload_t           rdata_o
);

  payload_t mem [NUM_SETS];

  // one access per cycle, read data appears after the edge
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* logic/wayMeta.sv */
`timescale 1ns/1ps

module wayMeta
  import cachePkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [INDEX_W-1:0] lookupIndex_i,
  input  logic               lookupEn_i,
  input  logic [TAG_W-1:0]   reqTag_i,
  input  logic [INDEX_W-1:0] reqIndex_i,
  input  tagEntry_t          tagWay0_i,
  input  tagEntry_t          tagWay1_i,
  input  logic               hitUpdate_i,
  input  logic               fillEn_i,
  output logic               hit_o,
  output logic               hitWay_o,
  output logic               victim_o
);

  // per set valid bits for each way and the least recently used way
  logic [NUM_SETS-1:0] valid0;
  logic [NUM_SETS-1:0] valid1;
  logic [NUM_SETS-1:0] lruWay;

  // valid bits sampled together with the SRAM read
  logic validQ0;
  logic validQ1;
  logic hit0;
  logic hit1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ0 <= 1'b0;
      validQ1 <= 1'b0;
    end else if (lookupEn_i) begin
      validQ0 <= valid0[lookupIndex_i];
      validQ1 <= valid1[lookupIndex_i];
    end
  end

  // tags come straight out of the tag SRAMs in the compare cycle
  assign hit0 = validQ0 && (tagWay0_i == reqTag_i);
  assign hit1 = validQ1 && (tagWay1_i == reqTag_i);

  assign hit_o    = hit0 || hit1;
  assign hitWay_o = hit1;

  // fill an empty way first, otherwise evict the LRU one
  always_comb begin
    if (!valid0[reqIndex_i]) begin
      victim_o = 1'b0;
    end else if (!valid1[reqIndex_i]) begin
      victim_o = 1'b1;
    end else begin
      victim_o = lruWay[reqIndex_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0 <= '0;
      valid1 <= '0;
      lruWay <= '0;
    end else if (fillEn_i) begin
      if (victim_o) begin
        valid1[reqIndex_i] <= 1'b1;
      end else begin
        valid0[reqIndex_i] <= 1'b1;
      end
      // freshly filled way becomes most recent
      lruWay[reqIndex_i] <= ~victim_o;
    end else if (hitUpdate_i) begin
      lruWay[reqIndex_i] <= ~hitWay_o;
    end
  end

endmodule

/* logic/refillUnit.sv */
`timescale 1ns/1ps

module refillUnit
  import cachePkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              memCredit_i,
  input  logic              refillStart_i,
  input  logic [ADDR_W-1:0] missAddr_i,
  output logic              memReq_o,
  output logic [ADDR_W-1:0] memAddr_o,
  input  logic              memRdValid_i,
  input  logic [XLEN-1:0]   memRdData_i,
  input  logic              memRdLast_i,
  output logic              refillDone_o,
  output logic [LINE_W-1:0] refillLine_o
);

  logic [CREDIT_W-1:0] creditCnt;
  // a miss waiting for a credit
  logic                pending;
  // request sent, beats not all back yet
  logic                inFlight;
  logic [ADDR_W-1:0]   lineAddr;
  logic [LINE_W-1:0]   lineBuf;
  logic                lastBeat;

  assign lastBeat = memRdValid_i && memRdLast_i;

  // one line fetch at a time, and only with a credit in hand
  assign memReq_o  = pending && !inFlight && (creditCnt != '0);
  assign memAddr_o = lineAddr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      creditCnt <= '0;
    end else begin
      creditCnt <= creditCnt + CREDIT_W'(memCredit_i) - CREDIT_W'(memReq_o);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending      <= 1'b0;
      inFlight     <= 1'b0;
      refillDone_o <= 1'b0;
    end else begin
      if (refillStart_i) begin
        pending <= 1'b1;
      end else if (memReq_o) begin
        pending <= 1'b0;
      end

      if (memReq_o) begin
        inFlight <= 1'b1;
      end else if (lastBeat) begin
        inFlight <= 1'b0;
      end

      // line buffer is complete the cycle after the last beat
      refillDone_o <= lastBeat;
    end
  end

  always_ff @(posedge clk) begin
    if (refillStart_i) begin
      lineAddr <= missAddr_i;
    end
  end

  // beats enter at the top, so the first (lowest) word ends up in bits 63:0
  always_ff @(posedge clk) begin
    if (memRdValid_i) begin
      lineBuf <= {memRdData_i, lineBuf[LINE_W-1 -: (BEATS-1)*XLEN]};
    end
  end

  assign refillLine_o = lineBuf;

endmodule

/* logic/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl
  import cachePkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  // pipeline side
  input  logic               valid_i,
  input  logic [ADDR_W-1:0]  addr_i,
  output logic               addr_ok_o,
  output logic               data_ok_o,
  output logic               data_notok_o,
  output logic [XLEN-1:0]    rd_data_o,
  // SRAM control, shared index for all six arrays
  output logic               ramEn_o,
  output logic               way0We_o,
  output logic               way1We_o,
  output logic [INDEX_W-1:0] ramIndex_o,
  output logic [HALF_W-1:0]  dataLo_o,
  output logic [HALF_W-1:0]  dataHi_o,
  output tagEntry_t          tagWdata_o,
  input  logic [HALF_W-1:0]  way0Lo_i,
  input  logic [HALF_W-1:0]  way0Hi_i,
  input  logic [HALF_W-1:0]  way1Lo_i,
  input  logic [HALF_W-1:0]  way1Hi_i,
  // metadata
  input  logic               hit_i,
  input  logic               hitWay_i,
  input  logic               victim_i,
  output logic               lookupEn_o,
  output logic               hitUpdate_o,
  output logic               fillEn_o,
  // refill
  output logic               refillStart_o,
  input  logic               refillDone_i,
  input  logic [LINE_W-1:0]  refillLine_i,
  output logic [TAG_W-1:0]   reqTag_o,
  output logic [INDEX_W-1:0] reqIndex_o,
  output logic [ADDR_W-1:0]  missAddr_o
);

  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    MISS,
    REFILL,
    WRITE,
    REREAD
  } state_t;

  state_t curState;
  state_t nextState;

  logic              accept;
  logic [ADDR_W-1:0] reqAddr;
  logic [LINE_W-1:0] hitLine;

  // new request can enter when idle or behind a hit
  assign addr_ok_o = (curState == IDLE) || ((curState == COMPARE) && hit_i);
  assign accept    = valid_i && addr_ok_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= IDLE;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      IDLE: begin
        if (valid_i) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (!hit_i) begin
          nextState = MISS;
        end else if (!valid_i) begin
          nextState = IDLE;
        end
      end
      // hand the line address over, refillUnit waits for the credit
      MISS: nextState = REFILL;
      REFILL: begin
        if (refillDone_i) begin
          nextState = WRITE;
        end
      end
      WRITE:  nextState = REREAD;
      REREAD: nextState = COMPARE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  assign reqTag_o   = reqAddr[ADDR_W-1 -: TAG_W];
  assign reqIndex_o = reqAddr[OFFSET_W +: INDEX_W];
  assign missAddr_o = {reqAddr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // read on acceptance and on re-read, write the victim way in WRITE
  assign ramEn_o    = accept || (curState == WRITE) || (curState == REREAD);
  assign ramIndex_o = accept ? addr_i[OFFSET_W +: INDEX_W] : reqIndex_o;
  assign way0We_o   = (curState == WRITE) && !victim_i;
  assign way1We_o   = (curState == WRITE) && victim_i;
  assign dataLo_o   = refillLine_i[HALF_W-1:0];
  assign dataHi_o   = refillLine_i[LINE_W-1:HALF_W];
  assign tagWdata_o = reqTag_o;

  assign lookupEn_o    = accept || (curState == REREAD);
  assign fillEn_o      = curState == WRITE;
  assign refillStart_o = curState == MISS;

  assign data_ok_o    = (curState == COMPARE) && hit_i;
  assign hitUpdate_o  = data_ok_o;
  assign data_notok_o = ((curState == COMPARE) && !hit_i) || (curState == MISS) ||
                        (curState == REFILL) || (curState == WRITE) ||
                        (curState == REREAD);

  // word select from the hitting way
  assign hitLine = hitWay_i ? {way1Hi_i, way1Lo_i} : {way0Hi_i, way0Lo_i};

  always_comb begin
    case (reqAddr[OFFSET_W-1:3])
      2'd0:    rd_data_o = hitLine[XLEN-1:0];
      2'd1:    rd_data_o = hitLine[2*XLEN-1:XLEN];
      2'd2:    rd_data_o = hitLine[3*XLEN-1:2*XLEN];
      default: rd_data_o = hitLine[4*XLEN-1:3*XLEN];
    endcase
  end

endmodule

/* logic/cacheTop.sv */
`timescale 1ns/1ps

module cacheTop
  import cachePkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              addr_ok_o,
  output logic              data_ok_o,
  output logic              data_notok_o,
  output logic [XLEN-1:0]   rd_data_o,
  output logic              memReq_o,
  output logic [ADDR_W-1:0] memAddr_o,
  input  logic              memCredit_i,
  input  logic              memRdValid_i,
  input  logic [XLEN-1:0]   memRdData_i,
  input  logic              memRdLast_i
);

  logic               ramEn;
  logic               way0We;
  logic               way1We;
  logic [INDEX_W-1:0] ramIndex;
  logic [HALF_W-1:0]  dataLo;
  logic [HALF_W-1:0]  dataHi;
  tagEntry_t          tagWdata;
  logic [HALF_W-1:0]  way0Lo;
  logic [HALF_W-1:0]  way0Hi;
  logic [HALF_W-1:0]  way1Lo;
  logic [HALF_W-1:0]  way1Hi;
  tagEntry_t          tagWay0;
  tagEntry_t          tagWay1;
  logic               hit;
  logic               hitWay;
  logic               victim;
  logic               lookupEn;
  logic               hitUpdate;
  logic               fillEn;
  logic               refillStart;
  logic               refillDone;
  logic [LINE_W-1:0]  refillLine;
  logic [TAG_W-1:0]   reqTag;
  logic [INDEX_W-1:0] reqIndex;
  logic [ADDR_W-1:0]  missAddr;

  cacheCtrl uCtrl (
    .clk, .rst_n, .valid_i, .addr_i, .addr_ok_o, .data_ok_o, .data_notok_o, .rd_data_o,
    .ramEn_o(ramEn), .way0We_o(way0We), .way1We_o(way1We), .ramIndex_o(ramIndex),
    .dataLo_o(dataLo), .dataHi_o(dataHi), .tagWdata_o(tagWdata),
    .way0Lo_i(way0Lo), .way0Hi_i(way0Hi), .way1Lo_i(way1Lo), .way1Hi_i(way1Hi),
    .hit_i(hit), .hitWay_i(hitWay), .victim_i(victim),
    .lookupEn_o(lookupEn), .hitUpdate_o(hitUpdate), .fillEn_o(fillEn),
    .refillStart_o(refillStart), .refillDone_i(refillDone), .refillLine_i(refillLine),
    .reqTag_o(reqTag), .reqIndex_o(reqIndex), .missAddr_o(missAddr)
  );

  wayMeta uMeta (
    .clk, .rst_n, .lookupIndex_i(ramIndex), .lookupEn_i(lookupEn),
    .reqTag_i(reqTag), .reqIndex_i(reqIndex), .tagWay0_i(tagWay0), .tagWay1_i(tagWay1),
    .hitUpdate_i(hitUpdate), .fillEn_i(fillEn),
    .hit_o(hit), .hitWay_o(hitWay), .victim_o(victim)
  );

  refillUnit uRefill (
    .clk, .rst_n, .memCredit_i, .refillStart_i(refillStart), .missAddr_i(missAddr),
    .memReq_o, .memAddr_o, .memRdValid_i, .memRdData_i, .memRdLast_i,
    .refillDone_o(refillDone), .refillLine_o(refillLine)
  );

  // data halves, way 0
  spRam #(.payload_t(logic [HALF_W-1:0])) uData0Lo (
    .clk, .en_i(ramEn), .we_i(way0We), .addr_i(ramIndex), .wdata_i(dataLo), .rdata_o(way0Lo)
  );
  spRam #(.payload_t(logic [HALF_W-1:0])) uData0Hi (
    .clk, .en_i(ramEn), .we_i(way0We), .addr_i(ramIndex), .wdata_i(dataHi), .rdata_o(way0Hi)
  );

  // data halves, way 1
  spRam #(.payload_t(logic [HALF_W-1:0])) uData1Lo (
    .clk, .en_i(ramEn), .we_i(way1We), .addr_i(ramIndex), .wdata_i(dataLo), .rdata_o(way1Lo)
  );
  spRam #(.payload_t(logic [HALF_W-1:0])) uData1Hi (
    .clk, .en_i(ramEn), .we_i(way1We), .addr_i(ramIndex), .wdata_i(dataHi), .rdata_o(way1Hi)
  );

  // tag arrays
  spRam #(.payload_t(tagEntry_t)) uTag0 (
    .clk, .en_i(ramEn), .we_i(way0We), .addr_i(ramIndex), .wdata_i(tagWdata), .rdata_o(tagWay0)
  );
  spRam #(.payload_t(tagEntry_t)) uTag1 (
    .clk, .en_i(ramEn), .we_i(way1We), .addr_i(ramIndex), .wdata_i(tagWdata), .rdata_o(tagWay1)
  );

endmodule

/* verif/cacheTb_chk.sv */
`timescale 1ns/1ps

module cacheTb_chk
  import cachePkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic memCredit_i,
  input logic memReq_i,
  input logic memRdValid_i,
  input logic addr_ok_i,
  input logic data_ok_i,
  input logic data_notok_i
);

  int unsigned failCount = 0;

  // totals seen on the memory bus since reset
  int unsigned grantTotal;
  int unsigned reqTotal;
  int unsigned beatTotal;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grantTotal <= 0;
      reqTotal   <= 0;
      beatTotal  <= 0;
    end else begin
      if (memCredit_i) begin
        grantTotal <= grantTotal + 1;
      end
      if (memReq_i) begin
        reqTotal <= reqTotal + 1;
      end
      if (memRdValid_i) begin
        beatTotal <= beatTotal + 1;
      end
    end
  end

  // a line request spends a credit granted earlier
  creditHeld: assert property (@(posedge clk) disable iff (!rst_n)
    memReq_i |-> reqTotal < grantTotal)
    else begin
      failCount++;
      $error("memory request issued without a credit");
    end

  // all beats of earlier lines are back before the next request
  singleFetch: assert property (@(posedge clk) disable iff (!rst_n)
    memReq_i |-> beatTotal == reqTotal * BEATS)
    else begin
      failCount++;
      $error("second line request while a fetch is in flight");
    end

  okExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(data_ok_i && data_notok_i))
    else begin
      failCount++;
      $error("data_ok and data_notok high together");
    end

  // no new request while a miss is resolved
  missStall: assert property (@(posedge clk) disable iff (!rst_n)
    data_notok_i |-> !addr_ok_i)
    else begin
      failCount++;
      $error("addr_ok high during a miss");
    end

endmodule

bind refillUnit cacheTb_chk creditChk (
  .clk, .rst_n, .memCredit_i, .memReq_i(memReq_o), .memRdValid_i,
  .addr_ok_i(1'b0), .data_ok_i(1'b0), .data_notok_i(1'b0)
);

bind cacheCtrl cacheTb_chk handshakeChk (
  .clk, .rst_n, .memCredit_i(1'b0), .memReq_i(1'b0), .memRdValid_i(1'b0),
  .addr_ok_i(addr_ok_o), .data_ok_i(data_ok_o), .data_notok_i(data_notok_o)
);

/* verif/cacheTb.sv */
`timescale 1ns/1ps

module cacheTb
  import cachePkg::*;
();

  logic              clk;
  logic              rst_n;
  logic              valid;
  logic [ADDR_W-1:0] addr;
  logic              addrOk;
  logic              dataOk;
  logic              dataNotOk;
  logic [XLEN-1:0]   rdData;
  logic              memReq;
  logic [ADDR_W-1:0] memAddr;
  logic              memCredit;
  logic              memRdValid;
  logic [XLEN-1:0]   memRdData;
  logic              memRdLast;

  // requests from the stim file
  logic [ADDR_W-1:0] stimAddr[$];
  int                stimGap[$];
  bit                stimHit[$];
  int                numReq;
  bit                stimLoaded;

  // accepted requests still waiting for data_ok_o
  int                pendingIdx[$];
  int                acceptCycle[$];
  int                curIdx;
  int                cycleCnt;
  int                respCount;
  bit                sawNotOk;

  // reference model of tag, valid and LRU per set
  logic [TAG_W-1:0]  modelTag [NUM_SETS][2];
  bit                modelValid [NUM_SETS][2];
  bit                modelLru [NUM_SETS];

  cacheTop uut (
    .clk, .rst_n, .valid_i(valid), .addr_i(addr), .addr_ok_o(addrOk), .data_ok_o(dataOk),
    .data_notok_o(dataNotOk), .rd_data_o(rdData), .memReq_o(memReq), .memAddr_o(memAddr),
    .memCredit_i(memCredit), .memRdValid_i(memRdValid), .memRdData_i(memRdData),
    .memRdLast_i(memRdLast)
  );

  // byte address in the upper half, its inverse in the lower half
  function automatic logic [XLEN-1:0] wordValue(input logic [ADDR_W-1:0] byteAddr);
    logic [ADDR_W-1:0] wordAddr;
    wordAddr = {byteAddr[ADDR_W-1:3], 3'b000};
    return {wordAddr, ~wordAddr};
  endfunction

  task automatic checkValue(input string testName, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", testName, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic abortRun(input string reason);
    $display("ERROR: %s", reason);
    $display("Regression failed");
    $fatal(1, "run aborted");
  endtask

  task automatic loadStim();
    int                fd;
    string             textLine;
    logic [ADDR_W-1:0] a;
    int                g;
    int                h;
    fd = $fopen("verif/cache_stim.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open verif/cache_stim.txt");
    end else begin
      // comment lines do not parse and are skipped
      while ($fgets(textLine, fd) != 0) begin
        if ($sscanf(textLine, "%h %d %d", a, g, h) == 3) begin
          stimAddr.push_back(a);
          stimGap.push_back(g);
          stimHit.push_back(h != 0);
        end
      end
      $fclose(fd);
      numReq = stimAddr.size();
    end
  endtask

  // hit or miss for one request, then fill and LRU update
  task automatic applyModel(input logic [ADDR_W-1:0] reqAddr, output bit hit);
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] setIdx;
    int                 way;
    int                 w;
    tag    = reqAddr[ADDR_W-1 -: TAG_W];
    setIdx = reqAddr[OFFSET_W +: INDEX_W];
    hit    = 1'b0;
    way    = 0;
    for (w = 0; w < 2; w++) begin
      if (modelValid[setIdx][w] && modelTag[setIdx][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // empty way first, else the least recently used one
      way = !modelValid[setIdx][0] ? 0 : (!modelValid[setIdx][1] ? 1 : (modelLru[setIdx] ? 1 : 0));
      modelValid[setIdx][way] = 1'b1;
      modelTag[setIdx][way]   = tag;
    end
    modelLru[setIdx] = (way == 0);
  endtask

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  initial begin
    int unsigned seedInit;
    bit          taken;
    int          tries;
    int          i;
    rst_n      = 1'b0;
    valid      = 1'b0;
    addr       = '0;
    memCredit  = 1'b0;
    memRdValid = 1'b0;
    memRdData  = '0;
    memRdLast  = 1'b0;
    seedInit   = $urandom(32'h3dd1_ae87);
    loadStim();
    if (numReq == 0) begin
      abortRun("no requests found in the stim file");
    end
    stimLoaded = 1'b1;
    repeat (4) @(posedge clk);
    #5 rst_n = 1'b1;
    @(negedge clk);
    checkValue("reset addr_ok", 64'd1, 64'(addrOk));
    checkValue("reset data_ok", 64'd0, 64'(dataOk));
    checkValue("reset data_notok", 64'd0, 64'(dataNotOk));
    checkValue("reset memReq", 64'd0, 64'(memReq));
    @(posedge clk);
    #5;
    for (i = 0; i < numReq; i++) begin
      if (stimGap[i] > 0) begin
        valid = 1'b0;
        repeat (stimGap[i]) begin
          @(posedge clk);
          #5;
        end
      end
      valid  = 1'b1;
      addr   = stimAddr[i];
      curIdx = i;
      taken  = 1'b0;
      tries  = 0;
      while (!taken) begin
        @(negedge clk);
        taken = addrOk;
        tries++;
        @(posedge clk);
        #5;
      end
      // from idle or behind a hit the request is taken in its first cycle
      if (i == 0 || stimHit[i-1]) begin
        checkValue($sformatf("request %0d accept delay", i), 64'd1, 64'(tries));
      end
    end
    valid = 1'b0;
    wait (respCount == numReq);
    repeat (4) @(posedge clk);
    if (uut.uRefill.creditChk.failCount + uut.uCtrl.handshakeChk.failCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("ERROR: bound assertions failed");
      $display("Regression failed");
    end
    $finish;
  end

  // response checker, sampled mid-cycle
  always @(negedge clk) begin
    int idx;
    int accCycle;
    bit predHit;
    if (rst_n === 1'b1) begin
      if (dataOk) begin
        if (pendingIdx.size() == 0) begin
          abortRun("data_ok_o seen with no request outstanding");
        end else begin
          idx      = pendingIdx.pop_front();
          accCycle = acceptCycle.pop_front();
          applyModel(stimAddr[idx], predHit);
          checkValue($sformatf("request %0d model vs stim", idx), 64'(stimHit[idx]),
                     64'(predHit));
          checkValue($sformatf("request %0d hit", idx), 64'(predHit), 64'(!sawNotOk));
          checkValue($sformatf("request %0d data", idx), wordValue(stimAddr[idx]), rdData);
          if (predHit) begin
            checkValue($sformatf("request %0d latency", idx), 64'd1,
                       64'(cycleCnt + 1 - accCycle));
          end
          sawNotOk = 1'b0;
          respCount++;
        end
      end else if (dataNotOk) begin
        sawNotOk = 1'b1;
      end
      if (valid && addrOk) begin
        pendingIdx.push_back(curIdx);
        acceptCycle.push_back(cycleCnt + 1);
      end
    end
  end

  // memory model grants one credit after reset and one per finished line
  initial begin
    logic [ADDR_W-1:0] lineAddr;
    int unsigned       gap;
    int                beat;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #5 memCredit = 1'b1;
    @(posedge clk);
    #5 memCredit = 1'b0;
    forever begin
      @(negedge clk);
      if (memReq) begin
        lineAddr = memAddr;
        checkValue("line address offset", 64'd0, 64'(memAddr[OFFSET_W-1:0]));
        gap = $urandom % 4;
        @(posedge clk);
        repeat (gap) @(posedge clk);
        for (beat = 0; beat < BEATS; beat++) begin
          #5;
          memRdValid = 1'b1;
          memRdData  = wordValue(lineAddr + ADDR_W'(8 * beat));
          memRdLast  = (beat == BEATS - 1);
          @(posedge clk);
        end
        #5;
        memRdValid = 1'b0;
        memRdLast  = 1'b0;
        memCredit  = 1'b1;
        @(posedge clk);
        #5 memCredit = 1'b0;
      end
    end
  end

  initial begin
    wait (stimLoaded);
    // reset plus 40 cycles per request
    repeat (4 + 40 * numReq) @(posedge clk);
    abortRun($sformatf("timeout with %0d of %0d requests answered", respCount, numReq));
  end

endmodule

/* verif/cache_stim.txt */
# columns: address (hex), idle cycles before the request, expected hit (1) or miss (0)
# set index is address bits 10:5, tag is bits 31:11
00000000 1 0
00000008 0 1
00000010 0 1
00000018 0 1
00000000 0 1
00000020 2 0
00000038 0 1
00000040 0 0
00000048 3 1
000007e0 1 0
000000a0 0 0
000008a8 0 0
000000b0 0 1
000008b8 0 1
000000a0 0 1
000010a8 2 0
000000b8 0 1
000008a0 0 0
000010b0 0 0
000000a8 1 0
00000028 0 1
000007f8 0 1
00000030 4 1

/* sources.f */
logic/cachePkg.sv
logic/spRam.sv
logic/wayMeta.sv
logic/refillUnit.sv
logic/cacheCtrl.sv
logic/cacheTop.sv
verif/cacheTb_chk.sv
verif/cacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module cacheTb \
  -Mdir obj_dir \
  -f sources.f

./obj_dir/VcacheTb | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "run.sh: PASS"
else
  echo "run.sh: FAIL, see sim.log"
  exit 1
fi
